// ==== rtl/lsu_pkg.sv ====
package lsu_pkg;

    localparam int xlen = 32;
    localparam int word_bytes = xlen / 8;
    localparam int align_w = $clog2(word_bytes);
    localparam int nw_width = 2;
    localparam int nr_bits = 5;

    typedef logic [xlen-1:0] data_t;
    typedef logic [xlen-align_w-1:0] mem_addr_t;
    typedef logic [nw_width-1:0] wid_t;
    typedef logic [nr_bits-1:0] reg_t;

    // loads first, then stores, then fence
    typedef enum logic [3:0] {
        op_lb,
        op_lh,
        op_lw,
        op_lbu,
        op_lhu,
        op_sb,
        op_sh,
        op_sw,
        op_fence
    } lsu_op_t;

    typedef struct packed {
        wid_t               wid;
        data_t              pc;
        lsu_op_t            op;
        reg_t               rd;
        logic signed [11:0] imm;
    } lsu_hdr_t;

    typedef struct packed {
        wid_t  wid;
        data_t pc;
        reg_t  rd;
        logic  wb;
    } commit_hdr_t;

    typedef struct packed {
        logic [word_bytes-1:0] byteen;
        mem_addr_t             addr;
        data_t                 data;
    } lane_req_t;

    // per-lane part of a queued load
    typedef struct packed {
        logic [align_w-1:0] align;
    } ld_lane_meta_t;

    typedef struct packed {
        commit_hdr_t hdr;
        lsu_op_t     op;
    } ld_meta_t;

    function automatic logic is_load(lsu_op_t op);
        return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
    endfunction

    function automatic logic is_store(lsu_op_t op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

    // log2 of access size in bytes
    function automatic logic [1:0] op_size(lsu_op_t op);
        case (op)
            op_lb, op_lbu, op_sb: return 2'd0;
            op_lh, op_lhu, op_sh: return 2'd1;
            default:              return 2'd2;
        endcase
    endfunction

endpackage

// ==== rtl/lsu_addr_gen.sv ====
`timescale 1ns/1ps

module lsu_addr_gen #(
    parameter int num_lanes = 4
) (
    input  lsu_pkg::lsu_hdr_t                      hdr,
    input  lsu_pkg::data_t [num_lanes-1:0]         rs1,
    input  lsu_pkg::data_t [num_lanes-1:0]         rs2,
    input  logic [num_lanes-1:0]                   tmask,
    output lsu_pkg::lane_req_t [num_lanes-1:0]     lanes,
    output lsu_pkg::ld_lane_meta_t [num_lanes-1:0] align
);
    import lsu_pkg::*;

    logic [1:0] size;
    logic       mem_op;

    assign size = op_size(hdr.op);
    assign mem_op = is_load(hdr.op) || is_store(hdr.op);

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        data_t              full_addr;
        logic [align_w-1:0] offset;
        logic               misaligned;

        assign full_addr = rs1[i] + data_t'(hdr.imm);
        assign offset = full_addr[align_w-1:0];

        assign lanes[i].addr = full_addr[xlen-1:align_w];
        assign align[i].align = offset;

        // store data moves up to the addressed byte lane
        assign lanes[i].data = rs2[i] << {offset, 3'b000};

        always_comb begin
            case (size)
                2'd0: lanes[i].byteen = word_bytes'(1) << offset;
                2'd1: lanes[i].byteen = word_bytes'(2'b11) << {offset[1], 1'b0};
                default: lanes[i].byteen = '1;
            endcase
        end

        always_comb begin
            case (size)
                2'd0: misaligned = 1'b0;
                2'd1: misaligned = offset[0];
                default: misaligned = |offset;
            endcase
        end

        // no split accesses in this unit
        always_comb begin
            if (tmask[i] && mem_op) begin
                assert (!misaligned)
                else $error("misaligned access, lane %0d, pc 0x%0h, addr 0x%0h, size %0d",
                            i, hdr.pc, full_addr, size);
            end
        end
    end

endmodule

// ==== rtl/lsu_load_queue.sv ====
`timescale 1ns/1ps

module lsu_load_queue #(
    parameter int num_lanes = 4,
    parameter int queue_depth = 4
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   push,
    input  lsu_pkg::ld_meta_t                      push_meta,
    input  logic [num_lanes-1:0]                   push_tmask,
    input  lsu_pkg::ld_lane_meta_t [num_lanes-1:0] push_lanes,
    input  logic                                   pop,
    output lsu_pkg::ld_meta_t                      head_meta,
    output logic [num_lanes-1:0]                   head_tmask,
    output lsu_pkg::ld_lane_meta_t [num_lanes-1:0] head_lanes,
    output logic                                   full,
    output logic                                   empty
);
    import lsu_pkg::*;

    localparam int ptr_w = $clog2(queue_depth);

    typedef struct packed {
        ld_meta_t                      meta;
        logic [num_lanes-1:0]          tmask;
        ld_lane_meta_t [num_lanes-1:0] lanes;
    } entry_t;

    entry_t entries [queue_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;

    assign full = (count == (ptr_w + 1)'(queue_depth));
    assign empty = (count == '0);

    // head is read straight out of the array
    assign head_meta = entries[rd_ptr].meta;
    assign head_tmask = entries[rd_ptr].tmask;
    assign head_lanes = entries[rd_ptr].lanes;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= '{meta: push_meta, tmask: push_tmask, lanes: push_lanes};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== rtl/lsu_load_format.sv ====
`timescale 1ns/1ps

module lsu_load_format #(
    parameter int num_lanes = 4
) (
    input  lsu_pkg::ld_meta_t                      meta,
    input  logic [num_lanes-1:0]                   tmask,
    input  lsu_pkg::ld_lane_meta_t [num_lanes-1:0] lanes,
    input  lsu_pkg::data_t [num_lanes-1:0]         rsp_data,
    output lsu_pkg::data_t [num_lanes-1:0]         lane_data
);
    import lsu_pkg::*;

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        logic [15:0] half;
        logic [7:0]  byte_val;
        data_t       value;

        // upper half first, then the byte within it
        assign half = lanes[i].align[1] ? rsp_data[i][31:16] : rsp_data[i][15:0];
        assign byte_val = lanes[i].align[0] ? half[15:8] : half[7:0];

        always_comb begin
            case (meta.op)
                op_lb:   value = {{(xlen-8){byte_val[7]}}, byte_val};
                op_lh:   value = {{(xlen-16){half[15]}}, half};
                op_lbu:  value = {{(xlen-8){1'b0}}, byte_val};
                op_lhu:  value = {{(xlen-16){1'b0}}, half};
                default: value = rsp_data[i];
            endcase
        end

        assign lane_data[i] = tmask[i] ? value : '0;
    end

endmodule

// ==== rtl/lsu_commit_arb.sv ====
`timescale 1ns/1ps

module lsu_commit_arb #(
    parameter int num_lanes = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           ld_valid,
    input  lsu_pkg::commit_hdr_t           ld_hdr,
    input  logic [num_lanes-1:0]           ld_tmask,
    input  lsu_pkg::data_t [num_lanes-1:0] ld_data,
    output logic                           ld_ready,
    input  logic                           st_valid,
    input  lsu_pkg::commit_hdr_t           st_hdr,
    input  logic [num_lanes-1:0]           st_tmask,
    output logic                           st_ready,
    output logic                           commit_valid,
    output lsu_pkg::commit_hdr_t           commit_hdr,
    output logic [num_lanes-1:0]           commit_tmask,
    output lsu_pkg::data_t [num_lanes-1:0] commit_data,
    input  logic                           commit_ready
);
    import lsu_pkg::*;

    logic                    ld_buf_valid;
    commit_hdr_t             ld_buf_hdr;
    logic [num_lanes-1:0]    ld_buf_tmask;
    data_t [num_lanes-1:0]   ld_buf_data;

    logic                    st_buf_valid;
    commit_hdr_t             st_buf_hdr;
    logic [num_lanes-1:0]    st_buf_tmask;

    logic ld_pop;
    logic st_pop;
    logic st_stalled;

    // load buffer wins whenever it holds an entry
    assign ld_pop = ld_buf_valid && commit_ready;
    assign st_pop = st_buf_valid && !ld_buf_valid && commit_ready;

    // a presented store must not be overtaken by a late load
    assign st_stalled = st_buf_valid && !ld_buf_valid && !commit_ready;

    assign ld_ready = ld_buf_valid ? ld_pop : !st_stalled;
    assign st_ready = !st_buf_valid || st_pop;

    assign commit_valid = ld_buf_valid || st_buf_valid;
    assign commit_hdr = ld_buf_valid ? ld_buf_hdr : st_buf_hdr;
    assign commit_tmask = ld_buf_valid ? ld_buf_tmask : st_buf_tmask;
    assign commit_data = ld_buf_valid ? ld_buf_data : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            ld_buf_valid <= 1'b0;
            st_buf_valid <= 1'b0;
        end else begin
            if (ld_valid && ld_ready) begin
                ld_buf_valid <= 1'b1;
            end else if (ld_pop) begin
                ld_buf_valid <= 1'b0;
            end
            if (st_valid && st_ready) begin
                st_buf_valid <= 1'b1;
            end else if (st_pop) begin
                st_buf_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_valid && ld_ready) begin
            ld_buf_hdr <= ld_hdr;
            ld_buf_tmask <= ld_tmask;
            ld_buf_data <= ld_data;
        end
        if (st_valid && st_ready) begin
            st_buf_hdr <= st_hdr;
            st_buf_tmask <= st_tmask;
        end
    end

endmodule

// ==== rtl/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top #(
    parameter int num_lanes = 4,
    parameter int queue_depth = 4
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               disp_valid,
    output logic                               disp_ready,
    input  lsu_pkg::lsu_hdr_t                  disp_hdr,
    input  logic [num_lanes-1:0]               disp_tmask,
    input  lsu_pkg::data_t [num_lanes-1:0]     disp_rs1,
    input  lsu_pkg::data_t [num_lanes-1:0]     disp_rs2,
    output logic                               mem_req_valid,
    output logic                               mem_req_rw,
    output logic [num_lanes-1:0]               mem_req_mask,
    output lsu_pkg::lane_req_t [num_lanes-1:0] mem_req_lanes,
    input  logic                               mem_req_ready,
    input  logic                               mem_rsp_valid,
    input  lsu_pkg::data_t [num_lanes-1:0]     mem_rsp_data,
    output logic                               mem_rsp_ready,
    output logic                               commit_valid,
    output lsu_pkg::commit_hdr_t               commit_hdr,
    output logic [num_lanes-1:0]               commit_tmask,
    output lsu_pkg::data_t [num_lanes-1:0]     commit_data,
    input  logic                               commit_ready
);
    import lsu_pkg::*;

    logic disp_is_load, disp_is_store, disp_is_fence;
    logic disp_fire, rsp_fire;
    logic q_full, q_empty;
    logic ld_ready, st_ready;

    ld_lane_meta_t [num_lanes-1:0] req_align, head_lanes;
    ld_meta_t                      push_meta, head_meta;
    logic [num_lanes-1:0]          head_tmask;
    data_t [num_lanes-1:0]         ld_data;
    commit_hdr_t                   st_hdr;

    assign disp_is_load = is_load(disp_hdr.op);
    assign disp_is_store = is_store(disp_hdr.op);
    assign disp_is_fence = (disp_hdr.op == op_fence);

    // request goes out only when the matching side has room
    assign mem_req_valid = disp_valid && ((disp_is_load && !q_full) || (disp_is_store && st_ready));
    assign mem_req_rw = disp_is_store;
    assign mem_req_mask = disp_tmask;

    always_comb begin
        if (disp_is_load || disp_is_store) begin
            disp_ready = mem_req_valid && mem_req_ready;
        end else if (disp_is_fence) begin
            // fence waits for every load to return
            disp_ready = q_empty && st_ready;
        end else begin
            disp_ready = 1'b0;
        end
    end

    assign disp_fire = disp_valid && disp_ready;
    assign mem_rsp_ready = ld_ready && !q_empty;
    assign rsp_fire = mem_rsp_valid && mem_rsp_ready;

    assign push_meta = '{hdr: '{wid: disp_hdr.wid, pc: disp_hdr.pc, rd: disp_hdr.rd, wb: 1'b1},
                         op: disp_hdr.op};
    assign st_hdr = '{wid: disp_hdr.wid, pc: disp_hdr.pc, rd: '0, wb: 1'b0};

    lsu_addr_gen #(.num_lanes(num_lanes)) addr_gen_inst (
        .hdr   (disp_hdr),
        .rs1   (disp_rs1),
        .rs2   (disp_rs2),
        .tmask (disp_tmask & {num_lanes{disp_valid}}),
        .lanes (mem_req_lanes),
        .align (req_align)
    );

    lsu_load_queue #(.num_lanes(num_lanes), .queue_depth(queue_depth)) load_queue_inst (
        .clk        (clk),
        .reset      (reset),
        .push       (disp_fire && disp_is_load),
        .push_meta  (push_meta),
        .push_tmask (disp_tmask),
        .push_lanes (req_align),
        .pop        (rsp_fire),
        .head_meta  (head_meta),
        .head_tmask (head_tmask),
        .head_lanes (head_lanes),
        .full       (q_full),
        .empty      (q_empty)
    );

    lsu_load_format #(.num_lanes(num_lanes)) load_format_inst (
        .meta      (head_meta),
        .tmask     (head_tmask),
        .lanes     (head_lanes),
        .rsp_data  (mem_rsp_data),
        .lane_data (ld_data)
    );

    lsu_commit_arb #(.num_lanes(num_lanes)) commit_arb_inst (
        .clk          (clk),
        .reset        (reset),
        .ld_valid     (rsp_fire),
        .ld_hdr       (head_meta.hdr),
        .ld_tmask     (head_tmask),
        .ld_data      (ld_data),
        .ld_ready     (ld_ready),
        .st_valid     (disp_fire && (disp_is_store || disp_is_fence)),
        .st_hdr       (st_hdr),
        .st_tmask     (disp_tmask),
        .st_ready     (st_ready),
        .commit_valid (commit_valid),
        .commit_hdr   (commit_hdr),
        .commit_tmask (commit_tmask),
        .commit_data  (commit_data),
        .commit_ready (commit_ready)
    );

endmodule

// ==== bench/lsu_properties.sv ====
`timescale 1ns/1ps

module lsu_properties #(
    parameter int num_lanes = 4
) (
    input logic                           clk,
    input logic                           reset,
    input logic                           commit_valid,
    input logic                           commit_ready,
    input lsu_pkg::commit_hdr_t           commit_hdr,
    input logic [num_lanes-1:0]           commit_tmask,
    input lsu_pkg::data_t [num_lanes-1:0] commit_data,
    input logic                           mem_req_valid,
    input logic                           mem_req_ready,
    input logic                           mem_req_rw,
    input logic                           mem_rsp_valid,
    input logic                           mem_rsp_ready
);

    // loads sent to memory and not yet answered
    logic [7:0] loads_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            loads_out <= '0;
        end else begin
            loads_out <= loads_out + 8'(mem_req_valid && mem_req_ready && !mem_req_rw)
                - 8'(mem_rsp_valid && mem_rsp_ready);
        end
    end

    // commit payload holds until taken
    commit_hold: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_hdr)
            && $stable(commit_tmask) && $stable(commit_data))
    else $error("commit_valid dropped or commit payload changed before commit_ready");

    commit_after_reset: assert property (@(posedge clk) reset |=> !commit_valid)
    else $error("commit_valid high in the cycle after reset");

    // responses only for loads in flight
    rsp_needs_load: assert property (@(posedge clk) disable iff (reset)
        loads_out == '0 |-> !mem_rsp_ready)
    else $error("mem_rsp_ready high with no load outstanding");

endmodule

// ==== bench/lsu_tb.sv ====
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int num_lanes = 4;
    localparam int queue_depth = 4;

    typedef struct packed {
        lsu_op_t               op;
        wid_t                  wid;
        data_t                 pc;
        reg_t                  rd;
        logic [11:0]           imm;
        logic [num_lanes-1:0]  tmask;
        data_t [num_lanes-1:0] rs1;
        data_t [num_lanes-1:0] rs2;
        logic                  wb;
        reg_t                  exp_rd;
        data_t [num_lanes-1:0] data;
    } test_t;

    logic                      clk;
    logic                      reset;
    logic                      disp_valid;
    logic                      disp_ready;
    lsu_hdr_t                  disp_hdr;
    logic [num_lanes-1:0]      disp_tmask;
    data_t [num_lanes-1:0]     disp_rs1;
    data_t [num_lanes-1:0]     disp_rs2;
    logic                      mem_req_valid;
    logic                      mem_req_rw;
    logic [num_lanes-1:0]      mem_req_mask;
    lane_req_t [num_lanes-1:0] mem_req_lanes;
    logic                      mem_req_ready = 1'b0;
    logic                      mem_rsp_valid = 1'b0;
    data_t [num_lanes-1:0]     mem_rsp_data = '0;
    logic                      mem_rsp_ready;
    logic                      commit_valid;
    commit_hdr_t               commit_hdr;
    logic [num_lanes-1:0]      commit_tmask;
    data_t [num_lanes-1:0]     commit_data;
    logic                      commit_ready = 1'b0;

    test_t                 tests [$];
    data_t                 init_words [256];
    data_t                 shadow [256];
    data_t                 mem [256];
    data_t [num_lanes-1:0] rsp_q [$];
    int                    due_q [$];
    logic [31:0]           seed = 32'h872e1481;
    int                    next_delay = 1;
    int                    cycles = 0;
    int                    cycle_limit = 0;
    int                    sent = 0;
    int                    checked = 0;
    int                    errors = 0;

    lsu_top #(.num_lanes(num_lanes), .queue_depth(queue_depth)) lsu_top_inst (.*);

    bind lsu_top lsu_properties #(.num_lanes(num_lanes)) props_inst (.*);

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // one table row with expected values from the shadow memory
    task automatic add_test(input lsu_op_t op, input reg_t rd, input logic [11:0] imm,
                            input logic [3:0] tmask, input data_t base, input data_t step);
        test_t      t;
        data_t      addr;
        logic [7:0] w;
        logic [1:0] off;
        data_t      val;
        t = '0;
        t.op = op;
        t.wid = wid_t'(tests.size());
        t.pc = 32'h1000 + 32'd4 * data_t'(tests.size());
        t.rd = rd;
        t.imm = imm;
        t.tmask = tmask;
        t.wb = op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
        t.exp_rd = t.wb ? rd : 5'd0;
        for (int i = 0; i < num_lanes; i++) begin
            t.rs1[i] = base + step * data_t'(i);
            t.rs2[i] = lcg_next();
            addr = t.rs1[i] + {{20{imm[11]}}, imm};
            w = addr[9:2];
            off = addr[1:0];
            val = shadow[w] >> (8 * off);
            if (tmask[i]) begin
                case (op)
                    op_sb:   shadow[w][8*off +: 8] = t.rs2[i][7:0];
                    op_sh:   shadow[w][8*off +: 16] = t.rs2[i][15:0];
                    op_sw:   shadow[w] = t.rs2[i];
                    op_lb:   t.data[i] = {{24{val[7]}}, val[7:0]};
                    op_lbu:  t.data[i] = {24'h0, val[7:0]};
                    op_lh:   t.data[i] = {{16{val[15]}}, val[15:0]};
                    op_lhu:  t.data[i] = {16'h0, val[15:0]};
                    op_lw:   t.data[i] = val;
                    default: t.data[i] = '0;
                endcase
            end
        end
        tests.push_back(t);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        logic [31:0] r;
        logic [3:0]  code;
        data_t       step;
        disp_valid = 1'b0;
        disp_hdr = '0;
        disp_tmask = '0;
        disp_rs1 = '0;
        disp_rs2 = '0;
        reset = 1'b1;
        for (int a = 0; a < 256; a++) begin
            init_words[a] = lcg_next() ^ data_t'(a);
            shadow[a] = init_words[a];
        end
        add_test(op_sw, 5'd0, 12'h000, 4'b1111, 32'h000, 32'd4);
        add_test(op_lw, 5'd5, 12'h000, 4'b1011, 32'h000, 32'd4);
        // stores may only follow loads behind a fence
        add_test(op_fence, 5'd0, 12'h000, 4'b1111, 32'h000, 32'd0);
        // step 5 walks byte offsets 0..3, step 6 walks half offsets 0 and 2
        add_test(op_sb, 5'd1, 12'h000, 4'b1111, 32'h100, 32'd5);
        add_test(op_sh, 5'd2, 12'h008, 4'b1111, 32'h138, 32'd6);
        add_test(op_sb, 5'd3, 12'hff0, 4'b0110, 32'h310, 32'd5);
        add_test(op_lw, 5'd6, 12'h000, 4'b1111, 32'h100, 32'd4);
        add_test(op_lw, 5'd7, 12'h000, 4'b1111, 32'h140, 32'd4);
        add_test(op_lw, 5'd8, 12'h000, 4'b1111, 32'h150, 32'd4);
        add_test(op_lw, 5'd9, 12'h000, 4'b1111, 32'h300, 32'd4);
        add_test(op_lb, 5'd10, 12'h000, 4'b1111, 32'h200, 32'd5);
        add_test(op_lbu, 5'd11, 12'h000, 4'b1111, 32'h200, 32'd5);
        add_test(op_lh, 5'd12, 12'hffc, 4'b1101, 32'h204, 32'd6);
        add_test(op_lhu, 5'd13, 12'h000, 4'b1111, 32'h200, 32'd6);
        add_test(op_lb, 5'd14, 12'h000, 4'b1111, 32'h101, 32'd1);
        add_test(op_fence, 5'd0, 12'h000, 4'b0011, 32'h000, 32'd0);
        add_test(op_sw, 5'd15, 12'h000, 4'b1010, 32'h3f0, 32'd4);
        add_test(op_sh, 5'd16, 12'h002, 4'b0111, 32'h3f0, 32'd4);
        add_test(op_lhu, 5'd17, 12'h000, 4'b1111, 32'h3f0, 32'd2);
        add_test(op_lw, 5'd18, 12'h000, 4'b1111, 32'h3f0, 32'd4);
        for (int n = 0; n < 6; n++) begin
            r = lcg_next();
            code = 4'(r[10:8] % 3'd5);
            step = (code == 4'd2) ? 32'd4 : (code == 4'd1 || code == 4'd4) ? 32'd2 : 32'd1;
            add_test(lsu_op_t'(code), r[28:24], 12'h000, r[3:0], {22'h0, r[23:16], 2'b00}, step);
        end
        cycle_limit = 200 * tests.size() + 100;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int n = 0; n < tests.size(); n++) begin
            disp_valid = 1'b1;
            disp_hdr = '{wid: tests[n].wid, pc: tests[n].pc, op: tests[n].op,
                         rd: tests[n].rd, imm: tests[n].imm};
            disp_tmask = tests[n].tmask;
            disp_rs1 = tests[n].rs1;
            disp_rs2 = tests[n].rs2;
            while (sent <= n) @(negedge clk);
        end
        disp_valid = 1'b0;
        wait (checked == tests.size());
        repeat (4) @(posedge clk);
        $display("%0d tests, %0d commits checked, %0d errors", tests.size(), checked, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        wait (cycle_limit > 0 && cycles >= cycle_limit);
        $display("timeout after %0d cycles, %0d of %0d instructions committed",
                 cycles, checked, tests.size());
        $display("Simulation failed");
        $finish;
    end

    // memory side and commit back-pressure
    always @(negedge clk) begin
        if (reset) begin
            mem_req_ready = 1'b0;
            commit_ready = 1'b0;
            mem_rsp_valid = 1'b0;
        end else begin
            mem_req_ready = ((lcg_next() >> 16) % 4) != 0;
            commit_ready = ((lcg_next() >> 16) % 3) != 0;
            next_delay = 1 + int'((lcg_next() >> 16) % 3);
            mem_rsp_valid = 1'b0;
            if (due_q.size() > 0) begin
                mem_rsp_valid = due_q[0] <= cycles;
                mem_rsp_data = rsp_q[0];
            end
        end
    end

    always @(posedge clk) begin : monitor
        data_t [num_lanes-1:0] words;
        logic [7:0]            idx;
        test_t                 exp;
        int                    errs_before;
        cycles++;
        if (reset) begin
            mem = init_words;
        end else begin
            if (disp_valid && disp_ready) begin
                sent++;
            end
            if (mem_req_valid && mem_req_ready) begin
                for (int i = 0; i < num_lanes; i++) begin
                    idx = mem_req_lanes[i].addr[7:0];
                    words[i] = mem[idx];
                    for (int b = 0; b < 4; b++) begin
                        if (mem_req_rw && mem_req_mask[i] && mem_req_lanes[i].byteen[b]) begin
                            mem[idx][8*b +: 8] = mem_req_lanes[i].data[8*b +: 8];
                        end
                    end
                end
                if (!mem_req_rw) begin
                    rsp_q.push_back(words);
                    due_q.push_back(cycles + next_delay);
                end
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                void'(rsp_q.pop_front());
                void'(due_q.pop_front());
            end
            if (commit_valid && commit_ready) begin
                if (checked >= tests.size()) begin
                    $display("extra commit at %0t for pc 0x%h after every instruction committed",
                             $time, commit_hdr.pc);
                    errors++;
                end else begin
                    exp = tests[checked];
                    errs_before = errors;
                    if (commit_hdr.wb !== exp.wb) begin
                        $display("FAIL %0t commit_hdr.wb expected %0d got %0d",
                                 $time, exp.wb, commit_hdr.wb);
                        errors++;
                    end
                    if (commit_hdr.rd !== exp.exp_rd) begin
                        $display("FAIL %0t commit_hdr.rd expected %0d got %0d",
                                 $time, exp.exp_rd, commit_hdr.rd);
                        errors++;
                    end
                    if (commit_hdr.wid !== exp.wid) begin
                        $display("FAIL %0t commit_hdr.wid expected %0d got %0d",
                                 $time, exp.wid, commit_hdr.wid);
                        errors++;
                    end
                    if (commit_hdr.pc !== exp.pc) begin
                        $display("FAIL %0t commit_hdr.pc expected 0x%h got 0x%h",
                                 $time, exp.pc, commit_hdr.pc);
                        errors++;
                    end
                    if (commit_tmask !== exp.tmask) begin
                        $display("FAIL %0t commit_tmask expected %b got %b",
                                 $time, exp.tmask, commit_tmask);
                        errors++;
                    end
                    for (int i = 0; i < num_lanes; i++) begin
                        if (commit_data[i] !== exp.data[i]) begin
                            $display("FAIL %0t commit_data[%0d] expected 0x%h got 0x%h",
                                     $time, i, exp.data[i], commit_data[i]);
                            errors++;
                        end
                    end
                    $display("test %0d %s pc 0x%h %s", checked, exp.op.name(), exp.pc,
                             (errors == errs_before) ? "ok" : "failed");
                    checked++;
                end
            end
        end
    end

endmodule

// ==== all.f ====
rtl/lsu_pkg.sv
rtl/lsu_addr_gen.sv
rtl/lsu_load_queue.sv
rtl/lsu_load_format.sv
rtl/lsu_commit_arb.sv
rtl/lsu_top.sv
bench/lsu_properties.sv
bench/lsu_tb.sv

// ==== Makefile ====
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := lsu_tb
FILE_LIST := all.f
BUILD_DIR := obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
